//--- sat_clause_top.f
+incdir+.
sat_types_pkg.sv
sat_ctrl_pkg.sv
clause_wr_if.sv
clause_loader.sv
clause_store.sv
clause_eval.sv
sat_clause_top.sv
sat_clause_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= sat_clause_tb
FILELIST  ?= sat_clause_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

SOURCES := $(filter %.sv,$(shell cat $(FILELIST))) $(wildcard *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sat_clause_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sat_settings.svh"

module sat_clause_tb import sat_types_pkg::*; ();

    localparam int NC      = `SAT_NUM_CLAUSES;
    localparam int NV      = `SAT_NUM_VARS;
    localparam int LW      = `SAT_WIDTH_LVL;
    localparam int NO      = `SAT_NUM_ORIG;
    localparam int TIMEOUT = 2000;                                   // run needs under 400 cycles

    logic          clk;
    logic          rst_n_i;
    var_vals_t     var_value_i;
    var_vals_t     var_value_o;
    lvls_t         var_lvl_i;
    lvls_t         var_lvl_o;
    logic [NV-1:0] participate_o;
    slot_mask_t    wr_i;
    slot_mask_t    rd_i;
    clause_t       clause_i;
    clause_t       clause_o;
    clen_t         clause_len_i;
    logic          add_learntc_en_i;
    logic          all_c_sat_o;
    logic          apply_imply_i;
    logic          apply_analyze_i;

    clause_t       mdl_clause [NC];                                  // shadow of the store
    clen_t         mdl_len    [NC];
    slot_mask_t    mdl_occ;
    clause_t       exp_clause;
    var_vals_t     exp_val;
    lvls_t         exp_lvl;
    logic [NV-1:0] exp_part;
    logic          exp_sat;
    logic          sat_chk;
    logic          reset_chk;
    integer        seed;
    int            cycle_cnt = 0;
    int            fail_cnt  = 0;

    sat_clause_top sat_clause_top_inst (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout after %0d cycles, the run did not reach its end", cycle_cnt);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic stop_on_mismatch(input string name, input logic [127:0] exp_v,
                                    input logic [127:0] got_v);
        fail_cnt = fail_cnt + 1;
        $display("Error %s exp=%0h got=%0h", name, exp_v, got_v);
        $display("Test failed");
        $fatal(1);
    endtask

    a_clause_o: assert property (@(posedge clk) disable iff (!rst_n_i)
        (|rd_i || reset_chk) |=> (clause_o == exp_clause))
        else stop_on_mismatch("clause_o", 128'(exp_clause), 128'(clause_o));
    a_var_value_o: assert property (@(posedge clk) disable iff (!rst_n_i)
        (apply_imply_i || reset_chk) |=> (var_value_o == exp_val))
        else stop_on_mismatch("var_value_o", 128'(exp_val), 128'(var_value_o));
    a_var_lvl_o: assert property (@(posedge clk) disable iff (!rst_n_i)
        (apply_imply_i || reset_chk) |=> (var_lvl_o == exp_lvl))
        else stop_on_mismatch("var_lvl_o", exp_lvl, var_lvl_o);
    a_participate_o: assert property (@(posedge clk) disable iff (!rst_n_i)
        (apply_analyze_i || reset_chk) |=> (participate_o == exp_part))
        else stop_on_mismatch("participate_o", 128'(exp_part), 128'(participate_o));
    a_all_c_sat_o: assert property (@(posedge clk) disable iff (!rst_n_i)
        sat_chk |-> (all_c_sat_o == exp_sat))
        else stop_on_mismatch("all_c_sat_o", 128'(exp_sat), 128'(all_c_sat_o));

    // expected imply, analyze and all-satisfied results for one assignment
    task automatic predict(input var_vals_t vals, input lvls_t lvls);
        logic [NV-1:0] taken;
        logic [NV-1:0] vars;
        lit_t          l;
        var_val_t      v_val;
        lvl_t          top;
        logic          sat;
        int            n_free;
        int            free_v;
        exp_val  = vals;
        exp_lvl  = lvls;
        exp_part = '0;
        exp_sat  = 1'b1;
        taken    = '0;
        for (int c = 0; c < NC; c++) begin
            vars   = '0;
            sat    = 1'b0;
            n_free = 0;
            free_v = 0;
            top    = '0;
            for (int v = 0; v < NV; v++) begin
                l     = mdl_clause[c][2*v +: 2];
                v_val = vals[2*v +: 2];
                if (l == LIT_POS || l == LIT_NEG) begin
                    vars[v] = 1'b1;
                    if (v_val == VAL_UNASSIGNED) begin
                        n_free = n_free + 1;
                        free_v = v;
                    end else if ((l == LIT_POS) == (v_val == VAL_TRUE)) begin
                        sat = 1'b1;
                    end else if (lvls[v*LW +: LW] > top) begin
                        top = lvls[v*LW +: LW];
                    end
                end
            end
            if (mdl_occ[c] && !sat) begin
                exp_sat = 1'b0;
                if (n_free == 0) begin
                    exp_part = exp_part | vars;
                end else if (n_free == 1 && !taken[free_v]) begin
                    taken[free_v] = 1'b1;                            // lower clause index keeps it
                    l = mdl_clause[c][2*free_v +: 2];
                    exp_val[2*free_v +: 2]   = (l == LIT_POS) ? VAL_TRUE : VAL_FALSE;
                    exp_lvl[free_v*LW +: LW] = top;
                end
            end
        end
    endtask

    function automatic clause_t rand_clause();
        clause_t cl;
        cl = clause_t'($random(seed));
        for (int v = 0; v < NV; v++) begin
            if (cl[2*v +: 2] == 2'b11) begin
                cl[2*v +: 2] = 2'b00;                                // not a legal literal
            end
        end
        if (cl == '0) begin
            cl[1:0] = LIT_POS;
        end
        return cl;
    endfunction

    function automatic var_vals_t rand_vals(input logic full);
        var_vals_t   r;
        logic [31:0] bits;
        bits = $random(seed);
        for (int v = 0; v < NV; v++) begin
            if (full) begin
                r[2*v +: 2] = bits[v] ? VAL_TRUE : VAL_FALSE;
            end else if (bits[2*v +: 2] == 2'b11) begin
                r[2*v +: 2] = VAL_UNASSIGNED;
            end else begin
                r[2*v +: 2] = bits[2*v +: 2];
            end
        end
        return r;
    endfunction

    function automatic lvls_t rand_lvls();
        lvls_t r;
        for (int v = 0; v < NV; v++) begin
            r[v*LW +: LW] = lvl_t'($random(seed));
        end
        return r;
    endfunction

    // every literal of cl made false, the first one left free when keep_free is set
    function automatic var_vals_t falsify(input var_vals_t base, input clause_t cl,
                                          input logic keep_free);
        var_vals_t r;
        lit_t      l;
        logic      left;
        r    = base;
        left = keep_free;
        for (int v = 0; v < NV; v++) begin
            l = cl[2*v +: 2];
            if (l == LIT_POS || l == LIT_NEG) begin
                if (left) begin
                    r[2*v +: 2] = VAL_UNASSIGNED;
                    left        = 1'b0;
                end else begin
                    r[2*v +: 2] = (l == LIT_POS) ? VAL_FALSE : VAL_TRUE;
                end
            end
        end
        return r;
    endfunction

    task automatic write_orig(input int slot, input clause_t cl, input clen_t len);
        sat_chk      = 1'b0;
        wr_i         = slot_mask_t'(1) << slot;
        clause_i     = cl;
        clause_len_i = len;
        @(negedge clk);
        wr_i             = '0;
        mdl_clause[slot] = cl;
        mdl_len[slot]    = len;
        mdl_occ[slot]    = 1'b1;
        repeat (2) @(negedge clk);
    endtask

    task automatic add_learnt(input clause_t cl, input clen_t len);
        int    victim;
        clen_t best;
        victim = -1;
        best   = '0;
        for (int s = NO; s < NC; s++) begin
            if (!mdl_occ[s] && victim < 0) begin
                victim = s;                                          // learnt area fills up first
            end
        end
        if (victim < 0) begin
            victim = NO;
            best   = mdl_len[NO];
            for (int s = NO + 1; s < NC; s++) begin
                if (mdl_len[s] > best) begin
                    best   = mdl_len[s];
                    victim = s;
                end
            end
        end
        sat_chk          = 1'b0;
        add_learntc_en_i = 1'b1;
        clause_i         = cl;
        clause_len_i     = len;
        @(negedge clk);
        add_learntc_en_i   = 1'b0;
        mdl_clause[victim] = cl;
        mdl_len[victim]    = len;
        mdl_occ[victim]    = 1'b1;
        repeat (2) @(negedge clk);
    endtask

    task automatic read_all();
        for (int s = 0; s < NC; s++) begin
            if (mdl_occ[s]) begin
                rd_i       = slot_mask_t'(1) << s;
                exp_clause = mdl_clause[s];
                @(negedge clk);
                rd_i = '0;
                @(negedge clk);
            end
        end
    endtask

    task automatic apply_vals(input var_vals_t vals, input lvls_t lvls);
        var_value_i = vals;
        var_lvl_i   = lvls;
        predict(vals, lvls);
        sat_chk         = 1'b1;
        apply_imply_i   = 1'b1;
        apply_analyze_i = 1'b1;
        @(negedge clk);
        apply_imply_i   = 1'b0;
        apply_analyze_i = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        int c;
        rst_n_i          = 1'b0;
        var_value_i      = '0;
        var_lvl_i        = '0;
        wr_i             = '0;
        rd_i             = '0;
        clause_i         = '0;
        clause_len_i     = '0;
        add_learntc_en_i = 1'b0;
        apply_imply_i    = 1'b0;
        apply_analyze_i  = 1'b0;
        exp_clause       = '0;
        exp_val          = '0;
        exp_lvl          = '0;
        exp_part         = '0;
        exp_sat          = 1'b1;                                     // nothing stored yet
        sat_chk          = 1'b0;
        reset_chk        = 1'b0;
        seed             = 32'h8497_e165;
        mdl_occ          = '0;
        for (int s = 0; s < NC; s++) begin
            mdl_clause[s] = '0;
            mdl_len[s]    = '0;
        end
        repeat (16) @(negedge clk);
        rst_n_i   = 1'b1;
        reset_chk = 1'b1;
        sat_chk   = 1'b1;
        @(negedge clk);
        reset_chk = 1'b0;
        @(negedge clk);
        for (int s = 0; s < NO; s++) begin
            write_orig(s, rand_clause(), clen_t'(($random(seed) & 7) + 1));
        end
        read_all();
        for (int k = 0; k < 10; k++) begin
            add_learnt(rand_clause(), clen_t'(($random(seed) & 7) + 1));
            read_all();
        end
        for (int k = 0; k < 20; k++) begin
            apply_vals(rand_vals(1'b1), rand_lvls());
        end
        for (int k = 0; k < 30; k++) begin
            c = $random(seed) & (NC - 1);
            apply_vals(falsify(rand_vals(1'b0), mdl_clause[c], 1'b1), rand_lvls());
        end
        for (int k = 0; k < 20; k++) begin
            c = $random(seed) & (NC - 1);
            apply_vals(falsify(rand_vals(1'b0), mdl_clause[c], 1'b0), rand_lvls());
        end
        if (fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sat_clause_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sat_settings.svh"

module sat_clause_top
    import sat_types_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n_i,

    input  wire var_vals_t  var_value_i,
    output var_vals_t       var_value_o,
    input  wire lvls_t      var_lvl_i,
    output lvls_t           var_lvl_o,
    output logic [`SAT_NUM_VARS-1:0] participate_o,                  // one bit per variable

    input  wire slot_mask_t wr_i,
    input  wire slot_mask_t rd_i,
    input  wire clause_t    clause_i,
    output clause_t         clause_o,
    input  wire clen_t      clause_len_i,

    input  wire logic       add_learntc_en_i,
    output logic            all_c_sat_o,
    input  wire logic       apply_imply_i,
    input  wire logic       apply_analyze_i
);

    clauses_t   clauses;
    slot_mask_t occupied;

    clause_wr_if wr_bus ();

    clause_loader clause_loader_inst (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .wr_i             (wr_i),
        .clause_i         (clause_i),
        .clause_len_i     (clause_len_i),
        .add_learntc_en_i (add_learntc_en_i),
        .wr               (wr_bus.loader)
    );

    clause_store clause_store_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wr         (wr_bus.store),
        .rd_i       (rd_i),
        .clause_o   (clause_o),
        .clauses_o  (clauses),
        .occupied_o (occupied)
    );

    clause_eval clause_eval_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .var_value_i     (var_value_i),
        .var_lvl_i       (var_lvl_i),
        .clauses_i       (clauses),
        .occupied_i      (occupied),
        .apply_imply_i   (apply_imply_i),
        .apply_analyze_i (apply_analyze_i),
        .var_value_o     (var_value_o),
        .var_lvl_o       (var_lvl_o),
        .participate_o   (participate_o),
        .all_c_sat_o     (all_c_sat_o)
    );

endmodule

`default_nettype wire

//--- clause_eval.sv
`timescale 1ns/1ps
`default_nettype none

`include "sat_settings.svh"

module clause_eval
    import sat_types_pkg::*;
    import sat_ctrl_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n_i,
    input  wire var_vals_t  var_value_i,
    input  wire lvls_t      var_lvl_i,
    input  wire clauses_t   clauses_i,
    input  wire slot_mask_t occupied_i,
    input  wire logic       apply_imply_i,
    input  wire logic       apply_analyze_i,
    output var_vals_t       var_value_o,
    output lvls_t           var_lvl_o,
    output logic [`SAT_NUM_VARS-1:0] participate_o,
    output logic            all_c_sat_o
);

    localparam int NC = `SAT_NUM_CLAUSES;
    localparam int NV = `SAT_NUM_VARS;
    localparam int LW = `SAT_WIDTH_LVL;

    clause_stat_e    stat     [NC];
    logic [NV-1:0]   present  [NC];                                  // variables that occur in the clause
    logic [NV-1:0]   free_msk [NC];
    var_val_t        unit_val [NC];                                  // value forced by the free literal
    lvl_t            max_lvl  [NC];
    var_vals_t       imp_vals;
    lvls_t           imp_lvls;
    logic [NV-1:0]   part;
    var_vals_t       val_q;
    lvls_t           lvl_q;
    logic [NV-1:0]   part_q;

    // classify every clause against the current assignment
    always_comb begin
        lit_t        lit;
        var_val_t    val;
        lvl_t        lv;
        logic        any_true;
        int unsigned n_free;
        for (int c = 0; c < NC; c++) begin
            any_true    = 1'b0;
            n_free      = 0;
            present[c]  = '0;
            free_msk[c] = '0;
            unit_val[c] = VAL_UNASSIGNED;
            max_lvl[c]  = '0;
            for (int v = 0; v < NV; v++) begin
                lit = clauses_i[c][2*v +: 2];
                val = var_value_i[2*v +: 2];
                lv  = var_lvl_i[v*LW +: LW];
                if (lit == LIT_POS || lit == LIT_NEG) begin
                    present[c][v] = 1'b1;
                    if ((lit == LIT_POS && val == VAL_TRUE) ||
                        (lit == LIT_NEG && val == VAL_FALSE)) begin
                        any_true = 1'b1;
                    end else if (val == VAL_UNASSIGNED) begin
                        n_free      = n_free + 1;
                        free_msk[c][v] = 1'b1;
                        unit_val[c] = (lit == LIT_POS) ? VAL_TRUE : VAL_FALSE;
                    end else if (lv > max_lvl[c]) begin
                        max_lvl[c] = lv;                             // level over false literals
                    end
                end
            end
            if (!occupied_i[c] || any_true) begin
                stat[c] = CS_SAT;                                    // empty slot never counts
            end else if (n_free == 0) begin
                stat[c] = CS_CONFLICT;
            end else if (n_free == 1) begin
                stat[c] = CS_UNIT;
            end else begin
                stat[c] = CS_OPEN;
            end
        end
    end

    // walk downwards so the lowest clause index is applied last
    always_comb begin
        imp_vals = var_value_i;
        imp_lvls = var_lvl_i;
        part     = '0;
        for (int c = NC - 1; c >= 0; c--) begin
            if (stat[c] == CS_UNIT) begin
                for (int v = 0; v < NV; v++) begin
                    if (free_msk[c][v]) begin
                        imp_vals[2*v +: 2]   = unit_val[c];
                        imp_lvls[v*LW +: LW] = max_lvl[c];
                    end
                end
            end
            if (stat[c] == CS_CONFLICT) begin
                part = part | present[c];
            end
        end
    end

    always_comb begin
        all_c_sat_o = 1'b1;
        for (int c = 0; c < NC; c++) begin
            if (stat[c] != CS_SAT) begin
                all_c_sat_o = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            val_q  <= '0;
            lvl_q  <= '0;
            part_q <= '0;
        end else begin
            if (apply_imply_i) begin
                val_q <= imp_vals;
                lvl_q <= imp_lvls;
            end
            if (apply_analyze_i) begin
                part_q <= part;
            end
        end
    end

    assign var_value_o   = val_q;
    assign var_lvl_o     = lvl_q;
    assign participate_o = part_q;

    // an imply may only change a variable that came in unassigned
    for (genvar v = 0; v < NV; v++) begin : g_imply_chk
        a_imply_unassigned: assert property (@(posedge clk) disable iff (!rst_n_i)
            apply_imply_i |=> (var_value_o[2*v +: 2] == $past(var_value_i[2*v +: 2])) ||
                              ($past(var_value_i[2*v +: 2]) == VAL_UNASSIGNED));
    end

endmodule

`default_nettype wire

//--- clause_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "sat_settings.svh"

module clause_store
    import sat_types_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n_i,
    clause_wr_if.store      wr,
    input  wire slot_mask_t rd_i,
    output clause_t         clause_o,
    output clauses_t        clauses_o,
    output slot_mask_t      occupied_o
);

    localparam int NUM_LEARNT = `SAT_NUM_CLAUSES - `SAT_NUM_ORIG;

    clauses_t     clauses_q;
    learnt_lens_t lens_q;
    slot_mask_t   occupied_q;
    clause_t      clause_q;
    clause_t      rd_data;

    // payload, written by the strobe only
    always_ff @(posedge clk) begin
        for (int i = 0; i < `SAT_NUM_CLAUSES; i++) begin
            if (wr.wr_mask[i]) begin
                clauses_q[i] <= wr.wr_clause;
            end
        end
        for (int j = 0; j < NUM_LEARNT; j++) begin
            if (wr.wr_mask[`SAT_NUM_ORIG + j]) begin
                lens_q[j] <= wr.wr_len;                              // only learnt lengths matter
            end
        end
    end

    // one-hot read mux
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < `SAT_NUM_CLAUSES; i++) begin
            if (rd_i[i]) begin
                rd_data = rd_data | clauses_q[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            occupied_q <= '0;
            clause_q   <= '0;
        end else begin
            occupied_q <= occupied_q | wr.wr_mask;
            if (|rd_i) begin
                clause_q <= rd_data;                                 // held until next read
            end
        end
    end

    // an empty learnt slot looks longest so the learnt area fills up first
    always_comb begin
        for (int j = 0; j < NUM_LEARNT; j++) begin
            if (occupied_q[`SAT_NUM_ORIG + j]) begin
                wr.learnt_lens[j] = lens_q[j];
            end else begin
                wr.learnt_lens[j] = '1;
            end
        end
    end

    assign clause_o   = clause_q;
    assign clauses_o  = clauses_q;
    assign occupied_o = occupied_q;

    a_rd_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(rd_i));

endmodule

`default_nettype wire

//--- clause_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "sat_settings.svh"

module clause_loader
    import sat_types_pkg::*;
    import sat_ctrl_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n_i,
    input  wire slot_mask_t wr_i,
    input  wire clause_t    clause_i,
    input  wire clen_t      clause_len_i,
    input  wire logic       add_learntc_en_i,
    clause_wr_if.loader     wr
);

    localparam int NUM_LEARNT = `SAT_NUM_CLAUSES - `SAT_NUM_ORIG;
    localparam int IDX_W      = $clog2(NUM_LEARNT);

    loader_state_e    state_q;
    loader_state_e    state_d;
    slot_mask_t       mask_q;
    clause_t          clause_q;
    clen_t            len_q;
    clen_t            best_len;
    logic [IDX_W-1:0] best_idx;
    slot_mask_t       victim;

    // learnt request wins over an original write
    always_comb begin
        if (add_learntc_en_i) begin
            state_d = LD_LEARNT;
        end else if (|wr_i) begin
            state_d = LD_ORIG;
        end else begin
            state_d = LD_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= LD_IDLE;
            mask_q  <= '0;
        end else begin
            state_q <= state_d;                                      // back to idle unless a new strobe
            if (state_d == LD_ORIG) begin
                mask_q <= wr_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_d != LD_IDLE) begin
            clause_q <= clause_i;
            len_q    <= clause_len_i;
        end
    end

    // max of four, strict compare keeps the lowest index on ties
    always_comb begin
        best_len = wr.learnt_lens[0];
        best_idx = '0;
        for (int j = 1; j < NUM_LEARNT; j++) begin
            if (wr.learnt_lens[j] > best_len) begin
                best_len = wr.learnt_lens[j];
                best_idx = IDX_W'(j);
            end
        end
        victim = '0;
        victim[`SAT_NUM_ORIG + best_idx] = 1'b1;
    end

    always_comb begin
        case (state_q)
            LD_ORIG:   wr.wr_mask = mask_q;
            LD_LEARNT: wr.wr_mask = victim;                          // lengths already include last write
            default:   wr.wr_mask = '0;
        endcase
    end

    assign wr.wr_clause = clause_q;
    assign wr.wr_len    = len_q;

    a_wr_mask_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(wr.wr_mask));

endmodule

`default_nettype wire

//--- clause_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface clause_wr_if import sat_types_pkg::*; ();

    slot_mask_t   wr_mask;                                           // one-cycle strobe, one-hot or zero
    clause_t      wr_clause;
    clen_t        wr_len;
    learnt_lens_t learnt_lens;                                       // lengths of slots 4 to 7

    modport loader (
        output wr_mask,
        output wr_clause,
        output wr_len,
        input  learnt_lens
    );

    modport store (
        input  wr_mask,
        input  wr_clause,
        input  wr_len,
        output learnt_lens
    );

endinterface

`default_nettype wire

//--- sat_ctrl_pkg.sv
`default_nettype none

package sat_ctrl_pkg;

    typedef enum logic [1:0] {
        LD_IDLE,                                                     // nothing pending
        LD_ORIG,                                                     // write to the strobed slot
        LD_LEARNT                                                    // write to the longest learnt slot
    } loader_state_e;

    typedef enum logic [1:0] {
        CS_SAT,                                                      // some literal true
        CS_UNIT,                                                     // one free literal, rest false
        CS_CONFLICT,                                                 // every literal false
        CS_OPEN                                                      // two or more free literals
    } clause_stat_e;

endpackage

`default_nettype wire

//--- sat_types_pkg.sv
`default_nettype none

`include "sat_settings.svh"

package sat_types_pkg;

    typedef logic [1:0] lit_t;                                       // one variable inside a clause
    typedef logic [2*`SAT_NUM_VARS-1:0] clause_t;
    typedef logic [1:0] var_val_t;
    typedef logic [2*`SAT_NUM_VARS-1:0] var_vals_t;
    typedef logic [`SAT_WIDTH_LVL-1:0] lvl_t;
    typedef logic [`SAT_NUM_VARS*`SAT_WIDTH_LVL-1:0] lvls_t;
    typedef logic [`SAT_WIDTH_C_LEN-1:0] clen_t;
    typedef logic [`SAT_NUM_CLAUSES-1:0] slot_mask_t;                // one bit per slot

    typedef clause_t [`SAT_NUM_CLAUSES-1:0] clauses_t;
    typedef clen_t [`SAT_NUM_CLAUSES-`SAT_NUM_ORIG-1:0] learnt_lens_t;

    // literal encoding, 00 is an absent variable
    localparam lit_t LIT_POS = 2'b01;
    localparam lit_t LIT_NEG = 2'b10;

    // variable value encoding
    localparam var_val_t VAL_UNASSIGNED = 2'b00;
    localparam var_val_t VAL_TRUE       = 2'b01;
    localparam var_val_t VAL_FALSE      = 2'b10;

endpackage

`default_nettype wire

//--- sat_settings.svh
`ifndef SAT_SETTINGS_SVH
`define SAT_SETTINGS_SVH

// clause array geometry
`define SAT_NUM_CLAUSES 8
`define SAT_NUM_VARS 8

// decision level and clause length widths
`define SAT_WIDTH_LVL 16
`define SAT_WIDTH_C_LEN 4

// slots below this index hold original clauses, the rest learnt ones
`define SAT_NUM_ORIG 4

`endif
